// File: src/thorPkg.sv
// ============================================================
// Shared widths, types and encodings of the execute core
// Opcode and function values are this core's own encoding
// Unknown opcode or function values yield a zero result
// ============================================================

package thorPkg;

	// Widths
	localparam int ValueWidth = 64;
	localparam int InsnWidth = 32;
	localparam int RegNoWidth = 6;
	localparam int ImmWidth = 14;
	localparam int NumRegs = 64;

	typedef logic [ValueWidth-1:0] value_t;
	typedef logic [2*ValueWidth-1:0] prod_t;
	typedef logic [InsnWidth-1:0] insn_t;
	typedef logic [RegNoWidth-1:0] regNo_t;
	typedef logic [ImmWidth-1:0] imm_t;

	// Major opcode in bits 5..0
	typedef enum logic [5:0] {
		R2 = 6'h02,
		ADDI = 6'h04,
		MULI = 6'h06,
		ANDI = 6'h08,
		ORI = 6'h09,
		XORI = 6'h0A,
		SLTI = 6'h0C,
		SLTUI = 6'h0D
	} opcode_e;

	// R2 function in bits 29..24
	typedef enum logic [5:0] {
		ADD = 6'h04,
		SUB = 6'h05,
		AND = 6'h08,
		OR = 6'h09,
		XOR = 6'h0A,
		MUL = 6'h10,
		MULU = 6'h14,
		MULH = 6'h18
	} func_e;

	// Sequencer states
	typedef enum logic [2:0] {
		RESTART1 = 3'd0,
		RESTART2 = 3'd1,
		RUN = 3'd2,
		MUL1 = 3'd3,
		MULWAIT = 3'd4,
		MULDONE = 3'd5
	} seqState_e;

endpackage

// File: src/thorIf.sv
// ============================================================
// Execute and writeback stage buses
// xRes flows back from the execute unit for bypassing
// ============================================================

`timescale 1ns/1ps

// Execute stage registers and the combinational result
interface exBus;
	import thorPkg::*;

	logic xValid;
	regNo_t xRt;
	value_t xA;
	value_t xB;
	value_t xImm;
	opcode_e xOp;
	func_e xFunc;
	logic xIsMul;
	value_t xRes;

	modport producer (output xValid, xRt, xA, xB, xImm, xOp, xFunc, xIsMul, input xRes);
	modport consumer (input xValid, xRt, xA, xB, xImm, xOp, xFunc, xIsMul, output xRes);
	modport seq (input xValid, xIsMul);
endinterface

// Writeback stage registers
interface wbBus;
	import thorPkg::*;

	logic wValid;
	regNo_t wRt;
	value_t wRes;

	modport producer (output wValid, wRt, wRes);
	modport consumer (input wValid, wRt, wRes);
endinterface

// File: src/coreSeq.sv
// ============================================================
// Restart and multiply sequencer, sole source of the stall
// busy is low in reset, high for the two restart cycles
// busy drops in MULDONE, one cycle before the product shows
// ============================================================

`timescale 1ns/1ps

module coreSeq (
	input logic clk_g,
	input logic rst_i,
	exBus.seq ex,
	input logic timerDone_i,
	output logic timerLoad_o,
	output logic mulStart_o,
	output logic mulDone_o,
	output logic hold_o,
	output logic busy_o
);
	import thorPkg::*;

	seqState_e state;
	seqState_e nextState;
	logic mulInEx;
	logic stall;

	assign mulInEx = ex.xValid && ex.xIsMul;

	// ============================================================
	// State machine
	// ============================================================
	always_comb begin
		nextState = state;
		case (state)
			RESTART1: nextState = RESTART2;
			RESTART2: nextState = RUN;
			RUN: if (mulInEx) nextState = MUL1;
			MUL1: nextState = MULWAIT;
			MULWAIT: if (timerDone_i) nextState = MULDONE;
			MULDONE: nextState = RUN;
			default: nextState = RESTART1;
		endcase
	end

	always_ff @(posedge clk_g) begin
		if (rst_i)
			state <= RESTART1;
		else
			state <= nextState;
	end

	// Operands latch and timer starts together
	assign mulStart_o = (state == MUL1);
	assign timerLoad_o = (state == MUL1);
	assign mulDone_o = (state == MULDONE);

	// MULDONE lets the next instruction in while the product moves to writeback
	assign stall = (state == RESTART1) || (state == RESTART2)
		|| (state == MUL1) || (state == MULWAIT)
		|| ((state == RUN) && mulInEx);

	assign hold_o = stall;
	// Top level outputs stay low while reset is held
	assign busy_o = stall && !rst_i;

	// ============================================================
	// Checks
	// ============================================================
	assert property (@(posedge clk_g) disable iff (rst_i)
		$onehot0({mulStart_o, mulDone_o}))
		else $error("mulStart and mulDone together");

	// Timer only finishes while a multiply is waiting on it
	assert property (@(posedge clk_g) disable iff (rst_i)
		timerDone_i |-> (state == MULWAIT))
		else $error("timer done outside MULWAIT");

endmodule

// File: src/mulTimer.sv
// ============================================================
// Multiplier latency timer
// done pulses exactly MulLatency cycles after load
// ============================================================

`timescale 1ns/1ps

module mulTimer #(
	parameter int MulLatency = 4
) (
	input logic clk_g,
	input logic rst_i,
	input logic load_i,
	output logic done_o
);
	localparam int CntWidth = $clog2(MulLatency + 1);

	logic [CntWidth-1:0] count;

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			count <= '0;
			done_o <= 1'b0;
		end else begin
			// Pulse on the step from one to zero
			done_o <= (count == CntWidth'(1));
			if (load_i)
				count <= CntWidth'(MulLatency);
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	assert property (@(posedge clk_g) disable iff (rst_i) load_i |-> (count == '0))
		else $error("timer reloaded while running");

endmodule

// File: src/operandStage.sv
// ============================================================
// Decode, register file, operand bypass and execute registers
// Register 0 reads as zero only for ADDI, otherwise it is stored
// Bypass order is execute result, writeback result, file
// ============================================================

`timescale 1ns/1ps

module operandStage (
	input logic clk_g,
	input logic rst_i,
	input logic insnValid_i,
	input thorPkg::insn_t insn_i,
	input logic hold_i,
	exBus.producer ex,
	wbBus.consumer wb
);
	import thorPkg::*;

	value_t regFile [NumRegs];
	opcode_e opcode;
	func_e func;
	regNo_t rt;
	regNo_t src [2];
	imm_t imm;
	value_t immExt;
	value_t opnd [2];
	logic isMul;

	// ============================================================
	// Field decode
	// ============================================================
	assign opcode = opcode_e'(insn_i[5:0]);
	assign rt = insn_i[11:6];
	assign src[0] = insn_i[17:12];
	assign src[1] = insn_i[23:18];
	assign func = func_e'(insn_i[29:24]);
	assign imm = insn_i[31:18];
	assign immExt = {{(ValueWidth-ImmWidth){imm[ImmWidth-1]}}, imm};

	assign isMul = (opcode == MULI)
		|| ((opcode == R2) && ((func == MUL) || (func == MULU) || (func == MULH)));

	// Operand fetch with bypass
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			if (ex.xValid && (src[i] == ex.xRt))
				opnd[i] = ex.xRes;
			else if (wb.wValid && (src[i] == wb.wRt))
				opnd[i] = wb.wRes;
			else
				opnd[i] = regFile[src[i]];
		end
		// Load immediate form
		if ((opcode == ADDI) && (src[0] == '0))
			opnd[0] = '0;
	end

	// Register file write from writeback
	always_ff @(posedge clk_g) begin
		if (wb.wValid)
			regFile[wb.wRt] <= wb.wRes;
	end

	// ============================================================
	// Execute stage registers
	// ============================================================
	always_ff @(posedge clk_g) begin
		if (rst_i)
			ex.xValid <= 1'b0;
		else if (!hold_i)
			ex.xValid <= insnValid_i;
	end

	always_ff @(posedge clk_g) begin
		if (!hold_i) begin
			ex.xRt <= rt;
			ex.xA <= opnd[0];
			ex.xB <= opnd[1];
			ex.xImm <= immExt;
			ex.xOp <= opcode;
			ex.xFunc <= func;
			ex.xIsMul <= isMul;
		end
	end

endmodule

// File: src/execUnit.sv
// ============================================================
// ALU, sign-magnitude multiplier and writeback registers
// Multiply result is only valid after mulDone, MulLatency >= 1
// MULH returns the high half, other multiplies the low half
// ============================================================

`timescale 1ns/1ps

module execUnit #(
	parameter int MulLatency = 4
) (
	input logic clk_g,
	input logic rst_i,
	input logic mulStart_i,
	input logic mulDone_i,
	exBus.consumer ex,
	wbBus.producer wb
);
	import thorPkg::*;

	value_t aluRes;
	value_t mulRes;
	value_t mulB;
	value_t absA;
	value_t absB;
	logic mulSigned;
	logic mulNeg;
	logic isMulH;
	logic wbWrite;
	value_t aaQ;
	value_t bbQ;
	logic signQ;
	prod_t prodPipe [MulLatency];
	prod_t prodFinal;

	// ============================================================
	// Single cycle ALU
	// ============================================================
	always_comb begin
		case (ex.xOp)
			R2:
				case (ex.xFunc)
					ADD: aluRes = ex.xA + ex.xB;
					SUB: aluRes = ex.xA - ex.xB;
					AND: aluRes = ex.xA & ex.xB;
					OR: aluRes = ex.xA | ex.xB;
					XOR: aluRes = ex.xA ^ ex.xB;
					default: aluRes = '0;
				endcase
			ADDI: aluRes = ex.xA + ex.xImm;
			ANDI: aluRes = ex.xA & ex.xImm;
			ORI: aluRes = ex.xA | ex.xImm;
			XORI: aluRes = ex.xA ^ ex.xImm;
			SLTI: aluRes = value_t'($signed(ex.xA) < $signed(ex.xImm));
			SLTUI: aluRes = value_t'(ex.xA < ex.xImm);
			default: aluRes = '0;
		endcase
	end

	// ============================================================
	// Multiplier
	// ============================================================
	// Only MULU treats its operands as unsigned
	assign mulSigned = !((ex.xOp == R2) && (ex.xFunc == MULU));
	assign mulB = (ex.xOp == MULI) ? ex.xImm : ex.xB;
	assign absA = (mulSigned && ex.xA[ValueWidth-1]) ? -ex.xA : ex.xA;
	assign absB = (mulSigned && mulB[ValueWidth-1]) ? -mulB : mulB;
	assign mulNeg = mulSigned && (ex.xA[ValueWidth-1] ^ mulB[ValueWidth-1]);
	assign isMulH = (ex.xOp == R2) && (ex.xFunc == MULH);

	always_ff @(posedge clk_g) begin
		if (mulStart_i) begin
			aaQ <= absA;
			bbQ <= absB;
			signQ <= mulNeg;
		end
	end

	// Magnitude product shifts down the chain
	always_ff @(posedge clk_g) begin
		prodPipe[0] <= prod_t'(aaQ) * prod_t'(bbQ);
		for (int i = 1; i < MulLatency; i++)
			prodPipe[i] <= prodPipe[i-1];
	end

	assign prodFinal = signQ ? -prodPipe[MulLatency-1] : prodPipe[MulLatency-1];
	assign mulRes = isMulH ? prodFinal[2*ValueWidth-1:ValueWidth] : prodFinal[ValueWidth-1:0];

	// Also the bypass value for the instruction behind a finished multiply
	assign ex.xRes = ex.xIsMul ? mulRes : aluRes;

	// ============================================================
	// Writeback registers
	// ============================================================
	assign wbWrite = (ex.xValid && !ex.xIsMul) || mulDone_i;

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			wb.wValid <= 1'b0;
			wb.wRt <= '0;
			wb.wRes <= '0;
		end else begin
			wb.wValid <= wbWrite;
			if (wbWrite) begin
				wb.wRt <= ex.xRt;
				wb.wRes <= ex.xRes;
			end
		end
	end

	// The multiply must still be parked in execute when it completes
	assert property (@(posedge clk_g) disable iff (rst_i)
		mulDone_i |-> (ex.xValid && ex.xIsMul))
		else $error("mulDone without a multiply in execute");

endmodule

// File: src/thorCore.sv
// ============================================================
// Execute core top level
// One instruction per strobe, accepted only while busy is low
// Writeback ports are a single cycle strobe, no back-pressure
// ============================================================

`timescale 1ns/1ps

module thorCore #(
	parameter int MulLatency = 4
) (
	input logic clk_g,
	input logic rst_i,
	input logic insnValid_i,
	input thorPkg::insn_t insn_i,
	output logic busy_o,
	output logic wbValid_o,
	output thorPkg::regNo_t wbReg_o,
	output thorPkg::value_t wbData_o
);
	exBus exIf ();
	wbBus wbIf ();

	logic hold;
	logic timerLoad;
	logic timerDone;
	logic mulStart;
	logic mulDone;

	coreSeq uCoreSeq (
		.clk_g (clk_g),
		.rst_i (rst_i),
		.ex (exIf.seq),
		.timerDone_i (timerDone),
		.timerLoad_o (timerLoad),
		.mulStart_o (mulStart),
		.mulDone_o (mulDone),
		.hold_o (hold),
		.busy_o (busy_o)
	);

	mulTimer #(.MulLatency(MulLatency)) uMulTimer (
		.clk_g (clk_g),
		.rst_i (rst_i),
		.load_i (timerLoad),
		.done_o (timerDone)
	);

	operandStage uOperandStage (
		.clk_g (clk_g),
		.rst_i (rst_i),
		.insnValid_i (insnValid_i),
		.insn_i (insn_i),
		.hold_i (hold),
		.ex (exIf.producer),
		.wb (wbIf.consumer)
	);

	execUnit #(.MulLatency(MulLatency)) uExecUnit (
		.clk_g (clk_g),
		.rst_i (rst_i),
		.mulStart_i (mulStart),
		.mulDone_i (mulDone),
		.ex (exIf.consumer),
		.wb (wbIf.producer)
	);

	// Writeback stage drives the result ports
	assign wbValid_o = wbIf.wValid;
	assign wbReg_o = wbIf.wRt;
	assign wbData_o = wbIf.wRes;

endmodule

// File: include/thorRefModel.svh
// ============================================================
// Reference model for the execute core testbench
// Operand values come from the caller's shadow register file
// ============================================================

`ifndef THOR_REF_MODEL_SVH
`define THOR_REF_MODEL_SVH

function automatic thorPkg::insn_t encR2(input thorPkg::func_e fn, input thorPkg::regNo_t rt,
		input thorPkg::regNo_t ra, input thorPkg::regNo_t rb);
	return {2'b00, fn, rb, ra, rt, thorPkg::R2};
endfunction

function automatic thorPkg::insn_t encImm(input thorPkg::opcode_e op, input thorPkg::regNo_t rt,
		input thorPkg::regNo_t ra, input thorPkg::imm_t imm);
	return {imm, ra, rt, op};
endfunction

function automatic thorPkg::value_t refSext(input thorPkg::imm_t imm);
	return {{(thorPkg::ValueWidth-thorPkg::ImmWidth){imm[thorPkg::ImmWidth-1]}}, imm};
endfunction

// Full product, then pick a half
function automatic thorPkg::value_t refMul(input logic isSigned, input logic hiHalf,
		input thorPkg::value_t a, input thorPkg::value_t b);
	thorPkg::prod_t p;
	if (isSigned)
		p = $signed({{thorPkg::ValueWidth{a[thorPkg::ValueWidth-1]}}, a})
			* $signed({{thorPkg::ValueWidth{b[thorPkg::ValueWidth-1]}}, b});
	else
		p = thorPkg::prod_t'(a) * thorPkg::prod_t'(b);
	return hiHalf ? p[2*thorPkg::ValueWidth-1:thorPkg::ValueWidth] : p[thorPkg::ValueWidth-1:0];
endfunction

function automatic thorPkg::value_t refResult(input thorPkg::opcode_e op,
		input thorPkg::func_e fn, input thorPkg::regNo_t ra, input thorPkg::value_t a,
		input thorPkg::value_t b, input thorPkg::imm_t imm);
	thorPkg::value_t opA;
	thorPkg::value_t immExt;
	opA = ((op == thorPkg::ADDI) && (ra == '0)) ? '0 : a;
	immExt = refSext(imm);
	case (op)
		thorPkg::R2:
			case (fn)
				thorPkg::ADD: return opA + b;
				thorPkg::SUB: return opA - b;
				thorPkg::AND: return opA & b;
				thorPkg::OR: return opA | b;
				thorPkg::XOR: return opA ^ b;
				thorPkg::MUL: return refMul(1'b1, 1'b0, opA, b);
				thorPkg::MULU: return refMul(1'b0, 1'b0, opA, b);
				thorPkg::MULH: return refMul(1'b1, 1'b1, opA, b);
				default: return '0;
			endcase
		thorPkg::ADDI: return opA + immExt;
		thorPkg::ANDI: return opA & immExt;
		thorPkg::ORI: return opA | immExt;
		thorPkg::XORI: return opA ^ immExt;
		thorPkg::SLTI: return thorPkg::value_t'($signed(opA) < $signed(immExt));
		thorPkg::SLTUI: return thorPkg::value_t'(opA < immExt);
		thorPkg::MULI: return refMul(1'b1, 1'b0, opA, immExt);
		default: return '0;
	endcase
endfunction

`endif

// File: tb/thorCore_tb.sv
// ============================================================
// Testbench for the execute core
// Expected results come from a shadow copy of the register file
// Every register is loaded before any test reads it
// ============================================================

`timescale 1ns/1ps

module thorCore_tb;
	import thorPkg::*;

	`include "thorRefModel.svh"

	// About 400 instructions at up to 12 cycles each, plus reset and drain
	localparam int InsnBudget = 400;
	localparam int CyclesPerInsn = 12;
	localparam int MaxCycles = InsnBudget * CyclesPerInsn + 1200;
	localparam int DrainCycles = 16;

	logic clk_g = 1'b0;
	logic rst_i;
	logic insnValid_i;
	insn_t insn_i;
	logic busy_o;
	logic wbValid_o;
	regNo_t wbReg_o;
	value_t wbData_o;

	value_t shadow [NumRegs];
	regNo_t expReg [$];
	value_t expData [$];
	int seed = 32'hddb0_e2f0;
	int passCount = 0;
	int failCount = 0;
	int cycles = 0;

	thorCore u_dut (
		.clk_g (clk_g),
		.rst_i (rst_i),
		.insnValid_i (insnValid_i),
		.insn_i (insn_i),
		.busy_o (busy_o),
		.wbValid_o (wbValid_o),
		.wbReg_o (wbReg_o),
		.wbData_o (wbData_o)
	);

	always #10 clk_g = ~clk_g;

	task automatic check(input bit ok, input string msg);
		assert (ok) passCount++;
		else begin
			$display("ERROR %0t: %s", $time, msg);
			failCount++;
		end
	endtask

	function automatic regNo_t randReg();
		return regNo_t'($random(seed));
	endfunction

	function automatic imm_t randImm();
		return imm_t'($random(seed));
	endfunction

	// Waits for busy low, then strobes one instruction for one cycle
	task automatic issue(input insn_t insn);
		regNo_t rt;
		regNo_t ra;
		regNo_t rb;
		value_t res;
		rt = insn[11:6];
		ra = insn[17:12];
		rb = insn[23:18];
		while (busy_o !== 1'b0) begin
			@(posedge clk_g);
			#2;
		end
		res = refResult(opcode_e'(insn[5:0]), func_e'(insn[29:24]), ra, shadow[ra],
			shadow[rb], insn[31:18]);
		shadow[rt] = res;
		expReg.push_back(rt);
		expData.push_back(res);
		insnValid_i = 1'b1;
		insn_i = insn;
		@(posedge clk_g);
		#2;
		insnValid_i = 1'b0;
	endtask

	task automatic endTest(input string name, input int failsBefore);
		int waited;
		waited = 0;
		while (expReg.size() != 0 && waited < DrainCycles) begin
			@(posedge clk_g);
			waited++;
		end
		repeat (3) @(posedge clk_g);
		#2;
		check(expReg.size() == 0,
			$sformatf("%0d writebacks missing after test %s", expReg.size(), name));
		$display("Test %s finished with %0d errors", name, failCount - failsBefore);
	endtask

	// ============================================================
	// Writeback compare
	// ============================================================
	always @(negedge clk_g) begin
		if (rst_i) begin
			check(wbValid_o === 1'b0, "wbValid_o high during reset");
			check(busy_o === 1'b0, "busy_o high during reset");
		end else if (wbValid_o === 1'b1) begin
			check(expReg.size() != 0,
				$sformatf("writeback to r%0d with no instruction outstanding", wbReg_o));
			if (expReg.size() != 0) begin
				check(wbReg_o == expReg[0],
					$sformatf("wbReg_o is r%0d, expected r%0d", wbReg_o, expReg[0]));
				check(wbData_o == expData[0], $sformatf("r%0d data %h, expected %h",
					expReg[0], wbData_o, expData[0]));
				expReg.delete(0);
				expData.delete(0);
			end
		end
	end

	initial begin
		while (cycles < MaxCycles) begin
			@(posedge clk_g);
			cycles++;
		end
		$display("Run stopped at the cycle limit of %0d before the tests finished", MaxCycles);
		$display("sim failed");
		$finish;
	end

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		int base;
		int n;
		regNo_t rt;
		regNo_t ra;
		regNo_t rb;
		regNo_t prev [2];
		opcode_e immOps [6];
		func_e aluFns [5];
		immOps = '{ADDI, ANDI, ORI, XORI, SLTI, SLTUI};
		aluFns = '{ADD, SUB, AND, OR, XOR};
		rst_i = 1'b1;
		insnValid_i = 1'b0;
		insn_i = '0;

		// Restart window, the strobed instruction must be dropped
		base = failCount;
		repeat (5) @(posedge clk_g);
		#2;
		rst_i = 1'b0;
		insnValid_i = 1'b1;
		insn_i = encImm(ADDI, 6'd5, 6'd0, 14'h0123);
		@(posedge clk_g);
		#2;
		check(busy_o === 1'b1, "busy_o was low in the first cycle after reset release");
		n = 0;
		while (busy_o === 1'b1 && n < 8) begin
			@(posedge clk_g);
			#2;
			n++;
		end
		insnValid_i = 1'b0;
		check(busy_o === 1'b0, "busy_o did not fall after the restart sequence");
		endTest("reset and restart", base);

		// Load every register, r0 gets a nonzero value
		base = failCount;
		for (int r = 0; r < NumRegs; r++)
			issue(encImm(ADDI, regNo_t'(r), 6'd0, (r == 0) ? 14'h1A5C : randImm()));
		for (int i = 0; i < 8; i++) begin
			rt = 6'd1 + regNo_t'($unsigned($random(seed)) % 63);
			if (i % 2 == 0)
				issue(encR2(ADD, rt, 6'd0, randReg()));
			else
				issue(encR2(ADD, rt, randReg(), 6'd0));
		end
		endTest("load immediate and r0", base);

		base = failCount;
		for (int i = 0; i < 80; i++)
			issue(encImm(immOps[$unsigned($random(seed)) % 6], randReg(), randReg(), randImm()));
		endTest("immediate ALU", base);

		// prev[0] hits the execute bypass, prev[1] the writeback bypass
		base = failCount;
		for (int c = 0; c < 16; c++) begin
			prev[0] = randReg();
			prev[1] = randReg();
			for (int i = 0; i < 5; i++) begin
				rt = randReg();
				if ($random(seed) & 1)
					issue(encR2(aluFns[$unsigned($random(seed)) % 5], rt, prev[0], prev[1]));
				else
					issue(encR2(aluFns[$unsigned($random(seed)) % 5], rt, prev[1], prev[0]));
				prev[1] = prev[0];
				prev[0] = rt;
			end
		end
		endTest("register ALU chains", base);

		// Wide operands in r40..r45 built 12 bits at a time
		base = failCount;
		for (int k = 0; k < 6; k++) begin
			rt = regNo_t'(40 + k);
			issue(encImm(ADDI, rt, 6'd0, randImm() & 14'h0FFF));
			for (int j = 0; j < 5; j++) begin
				issue(encImm(MULI, rt, rt, 14'd4096));
				issue(encImm(ORI, rt, rt, randImm() & 14'h0FFF));
			end
		end
		issue(encImm(ADDI, 6'd46, 6'd0, 14'd0));
		for (int k = 0; k < 3; k++)
			issue(encR2(SUB, regNo_t'(47 + k), 6'd46, regNo_t'(40 + k)));
		for (int i = 0; i < 40; i++) begin
			ra = regNo_t'(40 + $unsigned($random(seed)) % 10);
			rb = regNo_t'(40 + $unsigned($random(seed)) % 10);
			rt = regNo_t'(50 + $unsigned($random(seed)) % 14);
			case ($unsigned($random(seed)) % 4)
				0: issue(encR2(MUL, rt, ra, rb));
				1: issue(encR2(MULU, rt, ra, rb));
				2: issue(encR2(MULH, rt, ra, rb));
				default: issue(encImm(MULI, rt, ra, randImm()));
			endcase
			// Consumer of the product right behind it
			issue(encR2(aluFns[$unsigned($random(seed)) % 5],
				regNo_t'(50 + $unsigned($random(seed)) % 14), rt, rb));
		end
		endTest("multiply", base);

		$display("Checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
src/thorPkg.sv
src/thorIf.sv
src/coreSeq.sv
src/mulTimer.sv
src/operandStage.sv
src/execUnit.sv
src/thorCore.sv
tb/thorCore_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module thorCore_tb -o thorCore_sim

out=$(./obj_dir/thorCore_sim)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
